//--- axi_pkg.sv
package axi_pkg;

    // ----------------------------------------------------------------------
    // Channel widths
    // ----------------------------------------------------------------------
    localparam int axi_id_w   = 4;
    localparam int axi_addr_w = 32;
    localparam int axi_len_w  = 8;
    localparam int axi_size_w = 3;
    localparam int axi_user_w = 6;
    localparam int axi_data_w = 32;

    typedef enum logic [1:0] {
        burst_fixed = 2'b00,
        burst_incr  = 2'b01,
        burst_wrap  = 2'b10
    } axi_burst_e;

    // Higher code is the worse response
    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_exokay = 2'b01,
        resp_slverr = 2'b10,
        resp_decerr = 2'b11
    } axi_resp_e;

    localparam logic [axi_size_w-1:0] size_4_byte = 3'b010;
    localparam logic [axi_len_w-1:0]  burst_len   = 8'd3;  // 4 beats per burst

endpackage

//--- mst_pkg.sv
package mst_pkg;

    typedef enum logic [1:0] {
        slot_free   = 2'b00,
        slot_issue  = 2'b01,  // Allocated, AR not yet accepted
        slot_wait   = 2'b10,  // AR accepted, waiting for last beat
        slot_retire = 2'b11   // Complete, waiting for report
    } slot_state_e;

    typedef struct packed {
        logic [axi_pkg::axi_user_w-axi_pkg::axi_id_w-1:0] upper;
        logic [axi_pkg::axi_id_w-1:0]                     id;
    } req_split_t;

    // Request number as a whole, or split into upper part and AXI id
    typedef union packed {
        logic [axi_pkg::axi_user_w-1:0] num;
        req_split_t                     split;
    } req_tag_u;

    typedef struct packed {
        logic [axi_pkg::axi_addr_w-1:0] addr;
        axi_pkg::axi_burst_e            burst;
    } ar_pattern_t;

    function automatic ar_pattern_t pattern_lookup(input logic [2:0] idx);
        ar_pattern_t pat;
        case (idx)
            3'd0:    pat = '{32'h0000_0000, axi_pkg::burst_incr};
            3'd1:    pat = '{32'h0000_0010, axi_pkg::burst_incr};
            3'd2:    pat = '{32'h0000_0020, axi_pkg::burst_incr};
            3'd3:    pat = '{32'h0000_0030, axi_pkg::burst_fixed};
            3'd4:    pat = '{32'h0000_0034, axi_pkg::burst_wrap};
            3'd5:    pat = '{32'h0000_0038, axi_pkg::burst_wrap};
            3'd6:    pat = '{32'h0000_0040, axi_pkg::burst_fixed};
            default: pat = '{32'h0000_0050, axi_pkg::burst_incr};
        endcase
        return pat;
    endfunction

endpackage

//--- slot_if.sv
`timescale 1ns/1ps

interface slot_if #(
    parameter int ost_depth = 8
);
    localparam int ptr_w = $clog2(ost_depth);

    logic             set_en;         // Slot allocated this cycle
    logic [ptr_w-1:0] set_ptr;
    logic [ptr_w-1:0] issue_ptr;      // Oldest allocated, unissued
    logic             issue_pending;  // Some slot sits in ISSUE
    logic             ar_fire;
    logic [ptr_w-1:0] result_ptr;     // Oldest issued, incomplete
    logic             last_fire;
    logic             retire_en;      // Slot retired and reported
    logic [ptr_w-1:0] retire_ptr;

    modport ctrl (
        output set_en, set_ptr, issue_ptr, issue_pending, result_ptr, retire_en, retire_ptr,
        input  ar_fire, last_fire
    );

    modport ar (
        input  set_en, set_ptr, issue_ptr, issue_pending,
        output ar_fire
    );

    modport r (
        input  set_en, set_ptr, result_ptr, retire_en, retire_ptr,
        output last_fire
    );

endinterface

//--- slot_rr_arbiter.sv
`timescale 1ns/1ps

module slot_rr_arbiter #(
    parameter int ost_depth = 8
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [ost_depth-1:0]         request,
    input  logic                         advance,
    output logic [$clog2(ost_depth)-1:0] grant_ptr
);
    localparam int ptr_w = $clog2(ost_depth);

    logic [ptr_w-1:0] last_q;  // Index granted last

    // Walk downwards so the nearest requester after last_q wins
    always_comb begin
        int idx;
        grant_ptr = last_q;
        for (int k = ost_depth; k >= 1; k--) begin
            idx = (int'(last_q) + k) % ost_depth;
            if (request[idx]) begin
                grant_ptr = ptr_w'(idx);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_q <= ptr_w'(ost_depth - 1);  // First grant goes to slot 0
        end else if (advance) begin
            last_q <= grant_ptr;
        end
    end

endmodule

//--- rd_slot_ctrl.sv
`timescale 1ns/1ps

module rd_slot_ctrl #(
    parameter int ost_depth = 8
) (
    input  logic clk,
    input  logic rst_n,
    slot_if.ctrl slots,
    input  logic finish,
    input  logic report_ready_ok
);
    import mst_pkg::*;

    localparam int ptr_w = $clog2(ost_depth);

    slot_state_e          state_q [ost_depth];
    logic [ost_depth-1:0] free_vec;
    logic [ost_depth-1:0] issue_vec;
    logic [ost_depth-1:0] retire_vec;
    logic [ptr_w-1:0]     free_ptr;
    logic [ptr_w-1:0]     ret_ptr;

    // Queue 0 keeps the issue order, queue 1 the result order
    logic [ptr_w-1:0] q_mem [2][ost_depth];
    logic [ptr_w-1:0] q_rd [2];
    logic [ptr_w-1:0] q_wr [2];
    logic [ptr_w-1:0] q_head [2];
    logic [ptr_w-1:0] q_din [2];
    logic [1:0]       q_push;
    logic [1:0]       q_pop;

    always_comb begin
        for (int i = 0; i < ost_depth; i++) begin
            free_vec[i]   = (state_q[i] == slot_free);
            issue_vec[i]  = (state_q[i] == slot_issue);
            retire_vec[i] = (state_q[i] == slot_retire);
        end
    end

    slot_rr_arbiter #(.ost_depth(ost_depth)) i_free_arb (
        .clk       (clk),
        .rst_n     (rst_n),
        .request   (free_vec),
        .advance   (slots.set_en),
        .grant_ptr (free_ptr)
    );

    slot_rr_arbiter #(.ost_depth(ost_depth)) i_retire_arb (
        .clk       (clk),
        .rst_n     (rst_n),
        .request   (retire_vec),
        .advance   (slots.retire_en),
        .grant_ptr (ret_ptr)
    );

    assign slots.set_en        = (|free_vec) & ~finish;
    assign slots.set_ptr       = free_ptr;
    assign slots.issue_pending = |issue_vec;
    assign slots.issue_ptr     = q_head[0];
    assign slots.result_ptr    = q_head[1];
    assign slots.retire_en     = report_ready_ok;
    assign slots.retire_ptr    = ret_ptr;

    // ----------------------------------------------------------------------
    // Order queues
    // ----------------------------------------------------------------------
    assign q_push = {slots.ar_fire, slots.set_en};
    assign q_pop  = {slots.last_fire, slots.ar_fire};
    assign q_din[0] = slots.set_ptr;
    assign q_din[1] = q_head[0];  // Issued slot moves on to result order

    always_comb begin
        for (int q = 0; q < 2; q++) begin
            q_head[q] = q_mem[q][q_rd[q]];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int q = 0; q < 2; q++) begin
                q_rd[q] <= '0;
                q_wr[q] <= '0;
            end
        end else begin
            for (int q = 0; q < 2; q++) begin
                if (q_push[q]) q_wr[q] <= q_wr[q] + 1'b1;
                if (q_pop[q])  q_rd[q] <= q_rd[q] + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int q = 0; q < 2; q++) begin
            if (q_push[q]) q_mem[q][q_wr[q]] <= q_din[q];
        end
    end

    // ----------------------------------------------------------------------
    // Slot state machines
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < ost_depth; i++) begin
                state_q[i] <= slot_free;
            end
        end else begin
            for (int i = 0; i < ost_depth; i++) begin
                case (state_q[i])
                    slot_free:
                        if (slots.set_en && slots.set_ptr == ptr_w'(i)) state_q[i] <= slot_issue;
                    slot_issue:
                        if (slots.ar_fire && slots.issue_ptr == ptr_w'(i)) state_q[i] <= slot_wait;
                    slot_wait:
                        if (slots.last_fire && slots.result_ptr == ptr_w'(i))
                            state_q[i] <= slot_retire;
                    default:
                        if (slots.retire_en && slots.retire_ptr == ptr_w'(i)) state_q[i] <= slot_free;
                endcase
            end
        end
    end

    a_alloc_free: assert property (@(posedge clk) disable iff (!rst_n)
        slots.set_en |-> state_q[slots.set_ptr] == slot_free);

endmodule

//--- req_counter.sv
`timescale 1ns/1ps

module req_counter #(
    parameter int max_req_num = 32
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              count_en,
    output mst_pkg::req_tag_u tag,
    output logic              finish
);
    import axi_pkg::*;

    localparam int cnt_w = $clog2(max_req_num + 1);

    logic [cnt_w-1:0] count_q;  // Allocations so far

    assign tag.num = axi_user_w'(count_q);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count_q <= '0;
            finish  <= 1'b0;
        end else if (count_en && !finish) begin
            count_q <= count_q + 1'b1;
            finish  <= (int'(count_q) == max_req_num - 1);  // High once count hits max
        end
    end

    a_no_alloc_done: assert property (@(posedge clk) disable iff (!rst_n)
        !(count_en && finish));

endmodule

//--- ar_payload_store.sv
`timescale 1ns/1ps

module ar_payload_store #(
    parameter int ost_depth = 8
) (
    input  logic                           clk,
    input  logic                           rst_n,
    slot_if.ar                             slots,
    input  mst_pkg::req_tag_u              tag,
    output logic [axi_pkg::axi_id_w-1:0]   arid,
    output logic [axi_pkg::axi_addr_w-1:0] araddr,
    output logic [axi_pkg::axi_len_w-1:0]  arlen,
    output logic [axi_pkg::axi_size_w-1:0] arsize,
    output axi_pkg::axi_burst_e            arburst,
    output logic [axi_pkg::axi_user_w-1:0] aruser,
    output logic                           arvalid,
    input  logic                           arready
);
    import axi_pkg::*;
    import mst_pkg::*;

    req_tag_u    tag_mem [ost_depth];
    ar_pattern_t pat_mem [ost_depth];

    // Pattern follows the request number so slot choice does not matter
    always_ff @(posedge clk) begin
        if (slots.set_en) begin
            tag_mem[slots.set_ptr] <= tag;
            pat_mem[slots.set_ptr] <= pattern_lookup(tag.num[2:0]);
        end
    end

    assign arid    = tag_mem[slots.issue_ptr].split.id;
    assign aruser  = tag_mem[slots.issue_ptr].num;
    assign araddr  = pat_mem[slots.issue_ptr].addr;
    assign arburst = pat_mem[slots.issue_ptr].burst;
    assign arlen   = burst_len;
    assign arsize  = size_4_byte;

    assign arvalid       = slots.issue_pending;
    assign slots.ar_fire = arvalid & arready;

    // Issue queue head must hold until the handshake
    a_ar_stable: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid && !arready |=> arvalid && $stable(araddr) && $stable(aruser));

endmodule

//--- r_collector.sv
`timescale 1ns/1ps

module r_collector #(
    parameter int ost_depth = 8
) (
    input  logic                           clk,
    input  logic                           rst_n,
    slot_if.r                              slots,
    input  logic [axi_pkg::axi_id_w-1:0]   rid,
    input  logic [axi_pkg::axi_data_w-1:0] rdata,
    input  axi_pkg::axi_resp_e             rresp,
    input  logic                           rlast,
    input  logic                           rvalid,
    output logic                           rready,
    output logic                           report_valid,
    output logic [axi_pkg::axi_id_w-1:0]   report_id,
    output axi_pkg::axi_resp_e             report_resp,
    output logic                           report_err,
    output logic [axi_pkg::axi_len_w:0]    report_beats,
    input  logic                           report_ready,
    output logic                           report_ready_ok
);
    import axi_pkg::*;

    logic [axi_id_w-1:0]  id_mem    [ost_depth];
    axi_resp_e            resp_mem  [ost_depth];
    logic [axi_len_w:0]   beats_mem [ost_depth];
    logic [ost_depth-1:0] done_q;     // Last beat seen, report pending
    logic                 beat_fire;

    assign rready          = 1'b1;     // No back-pressure on R
    assign beat_fire       = rvalid & rready;
    assign slots.last_fire = beat_fire & rlast;

    // ----------------------------------------------------------------------
    // Per-slot beat merge
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (slots.set_en) begin
            resp_mem[slots.set_ptr]  <= resp_okay;
            beats_mem[slots.set_ptr] <= '0;
        end
        if (beat_fire) begin
            id_mem[slots.result_ptr]    <= rid;
            beats_mem[slots.result_ptr] <= beats_mem[slots.result_ptr] + 1'b1;
            resp_mem[slots.result_ptr]  <= (rresp > resp_mem[slots.result_ptr]) ?
                                           rresp : resp_mem[slots.result_ptr];  // Keep worst
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done_q <= '0;
        end else begin
            if (slots.last_fire) done_q[slots.result_ptr] <= 1'b1;
            if (slots.retire_en) done_q[slots.retire_ptr] <= 1'b0;
        end
    end

    // Report side
    assign report_valid    = done_q[slots.retire_ptr];
    assign report_id       = id_mem[slots.retire_ptr];
    assign report_resp     = resp_mem[slots.retire_ptr];
    assign report_beats    = beats_mem[slots.retire_ptr];
    assign report_err      = (report_resp == resp_slverr) || (report_resp == resp_decerr);
    assign report_ready_ok = report_valid & report_ready;

    // All beats of one burst carry the same id
    a_rid_match: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && beats_mem[slots.result_ptr] != '0 |-> rid == id_mem[slots.result_ptr]);

    a_r_known: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid |-> !$isunknown({rid, rdata, rlast}));

endmodule

//--- axi_rd_mst.sv
`timescale 1ns/1ps

module axi_rd_mst #(
    parameter int ost_depth   = 8,
    parameter int max_req_num = 32
) (
    input  logic                           clk,
    input  logic                           rst_n,
    output logic                           req_finish,
    // AR channel
    output logic [axi_pkg::axi_id_w-1:0]   arid,
    output logic [axi_pkg::axi_addr_w-1:0] araddr,
    output logic [axi_pkg::axi_len_w-1:0]  arlen,
    output logic [axi_pkg::axi_size_w-1:0] arsize,
    output axi_pkg::axi_burst_e            arburst,
    output logic [axi_pkg::axi_user_w-1:0] aruser,
    output logic                           arvalid,
    input  logic                           arready,
    // R channel
    input  logic [axi_pkg::axi_id_w-1:0]   rid,
    input  logic [axi_pkg::axi_data_w-1:0] rdata,
    input  axi_pkg::axi_resp_e             rresp,
    input  logic                           rlast,
    input  logic                           rvalid,
    output logic                           rready,
    // Completion report
    output logic                           report_valid,
    output logic [axi_pkg::axi_id_w-1:0]   report_id,
    output axi_pkg::axi_resp_e             report_resp,
    output logic                           report_err,
    output logic [axi_pkg::axi_len_w:0]    report_beats,
    input  logic                           report_ready
);
    import mst_pkg::*;

    req_tag_u tag;
    logic     report_ready_ok;

    slot_if #(.ost_depth(ost_depth)) slots ();

    rd_slot_ctrl #(.ost_depth(ost_depth)) i_ctrl (
        .clk             (clk),
        .rst_n           (rst_n),
        .slots           (slots.ctrl),
        .finish          (req_finish),
        .report_ready_ok (report_ready_ok)
    );

    req_counter #(.max_req_num(max_req_num)) i_req_cnt (
        .clk      (clk),
        .rst_n    (rst_n),
        .count_en (slots.set_en),
        .tag      (tag),
        .finish   (req_finish)
    );

    ar_payload_store #(.ost_depth(ost_depth)) i_ar_store (
        .clk     (clk),
        .rst_n   (rst_n),
        .slots   (slots.ar),
        .tag     (tag),
        .arid    (arid),
        .araddr  (araddr),
        .arlen   (arlen),
        .arsize  (arsize),
        .arburst (arburst),
        .aruser  (aruser),
        .arvalid (arvalid),
        .arready (arready)
    );

    r_collector #(.ost_depth(ost_depth)) i_r_coll (
        .clk             (clk),
        .rst_n           (rst_n),
        .slots           (slots.r),
        .rid             (rid),
        .rdata           (rdata),
        .rresp           (rresp),
        .rlast           (rlast),
        .rvalid          (rvalid),
        .rready          (rready),
        .report_valid    (report_valid),
        .report_id       (report_id),
        .report_resp     (report_resp),
        .report_err      (report_err),
        .report_beats    (report_beats),
        .report_ready    (report_ready),
        .report_ready_ok (report_ready_ok)
    );

endmodule

//--- tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int period = 8
) (
    output logic clk,
    output logic rst_n
);
    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (2) @(negedge clk);  // Two full cycles in reset
        rst_n = 1'b1;
    end

endmodule

//--- tb_axi_rd_mst.sv
`timescale 1ns/1ps

module tb_axi_rd_mst;
    import axi_pkg::*;

    localparam int num_req    = 32;
    localparam int sample_dly = 3;     // 1 ns before the rising edge
    localparam int max_cycles = 3000;
    localparam int quiet_win  = 40;    // Cycles with no AR after the last report

    // Expected AR pattern, indexed by the low 3 bits of the request number
    localparam logic [31:0] exp_addr [8] = '{32'h00, 32'h10, 32'h20, 32'h30,
                                             32'h34, 32'h38, 32'h40, 32'h50};
    localparam logic [1:0]  exp_burst [8] = '{2'd1, 2'd1, 2'd1, 2'd0,
                                              2'd2, 2'd2, 2'd0, 2'd1};

    typedef struct packed {
        logic [3:0][1:0] beat;  // rresp of each beat
        logic [1:0]      worst;
        logic            err;
    } req_entry_t;

    logic                  clk;
    logic                  rst_n;
    logic                  req_finish;
    logic [axi_id_w-1:0]   arid;
    logic [axi_addr_w-1:0] araddr;
    logic [axi_len_w-1:0]  arlen;
    logic [axi_size_w-1:0] arsize;
    axi_burst_e            arburst;
    logic [axi_user_w-1:0] aruser;
    logic                  arvalid;
    logic                  arready;
    logic [axi_id_w-1:0]   rid;
    logic [axi_data_w-1:0] rdata;
    axi_resp_e             rresp;
    logic                  rlast;
    logic                  rvalid;
    logic                  rready;
    logic                  report_valid;
    logic [axi_id_w-1:0]   report_id;
    axi_resp_e             report_resp;
    logic                  report_err;
    logic [axi_len_w:0]    report_beats;
    logic                  report_ready;

    req_entry_t            stim_tbl [num_req];
    logic [axi_user_w-1:0] user_q [$];   // Accepted ARs, slave side
    logic [axi_id_w-1:0]   id_q [$];
    logic [axi_user_w-1:0] cur_req;
    logic [axi_id_w-1:0]   cur_id;
    logic                  burst_active;
    int                    beat_idx;
    int                    stall_left;
    logic                  hold_pending;
    logic [15:0]           held;
    int                    ar_count;
    int                    rep_count;
    int                    mismatches;
    int                    other_errs;

    tb_clk_gen #(.period(8)) i_clk_gen (.clk(clk), .rst_n(rst_n));

    axi_rd_mst #(.ost_depth(8), .max_req_num(num_req)) i_dut (.*);

    // ----------------------------------------------------------------------
    // Check helpers
    // ----------------------------------------------------------------------
    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (exp === act) else begin
            mismatches++;
            $display("Mismatch %s: expected 0x%0h, actual 0x%0h", name, exp, act);
        end
    endtask

    task automatic require(input logic cond, input string what);
        assert (cond) else begin
            other_errs++;
            $display("Error: %s", what);
        end
    endtask

    task automatic build_table();
        logic [1:0] r;
        logic [1:0] worst;
        for (int n = 0; n < num_req; n++) begin
            worst = 2'd0;
            for (int b = 0; b < 4; b++) begin
                r = (($urandom % 8) < 5) ? 2'd0 : 2'($urandom % 4);  // Mostly OKAY
                stim_tbl[n].beat[b] = r;
                if (r > worst) worst = r;
            end
            stim_tbl[n].worst = worst;
            stim_tbl[n].err   = (worst == 2'b10) || (worst == 2'b11);  // SLVERR or DECERR
        end
    endtask

    // ----------------------------------------------------------------------
    // Slave model and report sink, driven on the falling edge
    // ----------------------------------------------------------------------
    task automatic drive_inputs();
        arready = ($urandom % 4) != 0;
        if (!burst_active && user_q.size() > 0) begin
            cur_req      = user_q.pop_front();
            cur_id       = id_q.pop_front();
            beat_idx     = 0;
            burst_active = 1'b1;
        end
        if (burst_active && ($urandom % 3) != 0) begin
            rvalid = 1'b1;
            rid    = cur_id;
            rresp  = axi_resp_e'(stim_tbl[cur_req].beat[beat_idx]);
            rlast  = (beat_idx == 3);
            rdata  = $urandom;
        end else begin
            rvalid = 1'b0;
            rlast  = 1'b0;
        end
        if (stall_left > 0) begin
            report_ready = 1'b0;
            stall_left--;
        end else if (($urandom % 6) == 0) begin
            report_ready = 1'b0;
            stall_left   = int'($urandom % 6);  // Random stall stretch
        end else begin
            report_ready = 1'b1;
        end
    endtask

    task automatic check_report();
        string tn;
        tn = $sformatf("report[%0d]", rep_count);
        if (rep_count == 0) begin
            require(ar_count >= 2, "fewer than two ARs were accepted before the first report");
        end
        if (rep_count >= num_req) begin
            require(1'b0, "a report arrived after all requests were reported");
        end else begin
            check_value({tn, " id"}, 32'(rep_count % 16), 32'(report_id));
            check_value({tn, " beats"}, 32'd4, 32'(report_beats));
            check_value({tn, " resp"}, 32'(stim_tbl[rep_count].worst), 32'(report_resp));
            check_value({tn, " err"}, 32'(stim_tbl[rep_count].err), 32'(report_err));
        end
        rep_count++;
    endtask

    task automatic check_ar();
        string tn;
        tn = $sformatf("ar[%0d]", ar_count);
        if (ar_count >= num_req) begin
            require(1'b0, "an AR was accepted after all requests were issued");
        end else begin
            check_value({tn, " aruser"}, 32'(ar_count), 32'(aruser));
            check_value({tn, " arid"}, 32'(ar_count % 16), 32'(arid));
            check_value({tn, " arlen"}, 32'd3, 32'(arlen));
            check_value({tn, " arsize"}, 32'd2, 32'(arsize));
            check_value({tn, " araddr"}, exp_addr[ar_count % 8], araddr);
            check_value({tn, " arburst"}, 32'(exp_burst[ar_count % 8]), 32'(arburst));
            if (int'(aruser) < num_req) begin
                user_q.push_back(aruser);
                id_q.push_back(arid);
            end
        end
        ar_count++;
    endtask

    // Everything here sees the values that the next rising edge samples
    task automatic sample_cycle();
        if (hold_pending) begin
            require(report_valid, "report_valid dropped while report_ready was low");
            check_value("report hold", 32'(held),
                        32'({report_id, report_resp, report_err, report_beats}));
        end
        hold_pending = report_valid && !report_ready;
        held         = {report_id, report_resp, report_err, report_beats};
        if (report_valid && report_ready) check_report();
        if (arvalid && arready) check_ar();
        check_value("rready", 32'd1, 32'(rready));  // R is never back-pressured
        if (rvalid && rready) begin
            beat_idx++;
            if (beat_idx == 4) burst_active = 1'b0;
        end
        if (ar_count >= num_req) check_value("req_finish", 32'd1, 32'(req_finish));
    endtask

    // ----------------------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------------------
    initial begin
        int          tmo;
        int          cyc;
        int          quiet;
        arready      = 1'b0;
        rid          = '0;
        rdata        = '0;
        rresp        = resp_okay;
        rlast        = 1'b0;
        rvalid       = 1'b0;
        report_ready = 1'b0;
        burst_active = 1'b0;
        beat_idx     = 0;
        stall_left   = 0;
        hold_pending = 1'b0;
        held         = '0;
        ar_count     = 0;
        rep_count    = 0;
        mismatches   = 0;
        other_errs   = 0;
        void'($urandom(32'hb7f48035));
        build_table();

        tmo = 0;
        do begin
            @(negedge clk);
            #sample_dly;
            check_value("reset arvalid", 32'd0, 32'(arvalid));
            check_value("reset report_valid", 32'd0, 32'(report_valid));
            check_value("reset req_finish", 32'd0, 32'(req_finish));
            tmo++;
        end while (!rst_n && tmo < 20);
        require(rst_n, "timed out waiting for reset release");

        cyc   = 0;
        quiet = 0;
        while (rst_n && cyc < max_cycles && quiet < quiet_win) begin
            @(negedge clk);
            drive_inputs();
            #sample_dly;
            sample_cycle();
            if (rep_count >= num_req) quiet++;
            cyc++;
        end
        require(cyc < max_cycles, "timed out waiting for all reports");
        check_value("total ARs", 32'(num_req), 32'(ar_count));
        check_value("total reports", 32'(num_req), 32'(rep_count));

        $display("Errors: %0d mismatches, %0d other", mismatches, other_errs);
        if (mismatches == 0 && other_errs == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- sim.f
axi_pkg.sv
mst_pkg.sv
slot_if.sv
slot_rr_arbiter.sv
rd_slot_ctrl.sv
req_counter.sv
ar_payload_store.sv
r_collector.sv
axi_rd_mst.sv
tb_clk_gen.sv
tb_axi_rd_mst.sv

//--- Makefile
SOURCES := $(shell cat sim.f)

obj_dir/Vtb_axi_rd_mst: sim.f $(SOURCES)
	verilator --binary --assert --top-module tb_axi_rd_mst -f sim.f

.PHONY: run clean

run: obj_dir/Vtb_axi_rd_mst
	out="$$(./obj_dir/Vtb_axi_rd_mst)"; echo "$$out"; \
	echo "$$out" | grep -qx "Simulation PASSED"

clean:
	rm -rf obj_dir
